// File: alu.sv
// Combinational RV32I ALU, one operation per cycle selected by the ALU operation code
`timescale 1ns/1ps
`include "rv_config.svh"

module alu import rv_pkg::*; (
    input  word_t   alu_op1_i,
    input  word_t   alu_op2_i,
    input  alu_op_t alu_func_i,
    output word_t   alu_out_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shifts only look at the low five bits
    assign shamt       = alu_op2_i[4:0];
    assign lt_signed   = $signed(alu_op1_i) < $signed(alu_op2_i);
    assign lt_unsigned = alu_op1_i < alu_op2_i;

    always_comb begin
        case (alu_func_i)
            `ALU_OP_ADD:  alu_out_o = alu_op1_i + alu_op2_i;
            `ALU_OP_SUB:  alu_out_o = alu_op1_i - alu_op2_i;
            `ALU_OP_SLL:  alu_out_o = alu_op1_i << shamt;
            `ALU_OP_SLT:  alu_out_o = word_t'(lt_signed);
            `ALU_OP_SLTU: alu_out_o = word_t'(lt_unsigned);
            `ALU_OP_XOR:  alu_out_o = alu_op1_i ^ alu_op2_i;
            `ALU_OP_SRL:  alu_out_o = alu_op1_i >> shamt;
            `ALU_OP_SRA:  alu_out_o = word_t'($signed(alu_op1_i) >>> shamt);
            `ALU_OP_OR:   alu_out_o = alu_op1_i | alu_op2_i;
            `ALU_OP_AND:  alu_out_o = alu_op1_i & alu_op2_i;
            // NOP and unused codes
            default:      alu_out_o = '0;
        endcase
    end

endmodule

// File: arith.sv
// Arithmetic unit: decodes an issued instruction, selects ALU operands and registers the writeback
`timescale 1ns/1ps
`include "rv_config.svh"

module arith import rv_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      issue_valid_i,
    input  word_t     pc_i,
    input  inst_t     inst_i,
    rf_read_if.requester rd_port,
    output word_t     alu_op1_o,
    output word_t     alu_op2_o,
    output alu_op_t   alu_func_o,
    input  word_t     alu_out_i,
    output logic      writeback_valid_o,
    output reg_addr_t writeback_rd_o,
    output word_t     writeback_value_o
);

    // ******************************************************************
    // instruction fields
    // ******************************************************************

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic [4:0] shamt;
    word_t      imm_i;
    word_t      imm_u;
    logic       f7_base;
    logic       f7_alt;
    alu_op_t    base_func;
    logic       inst_legal;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];
    assign shamt  = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};

    assign f7_base = (funct7 == `FUNCT7_BASE);
    assign f7_alt  = (funct7 == `FUNCT7_ALT);

    // operand values come back in the same cycle
    assign rd_port.rs1_addr = rs1;
    assign rd_port.rs2_addr = rs2;

    // ******************************************************************
    // operation and operand select
    // ******************************************************************

    // funct3 to ALU code, common to OP and OP-IMM
    always_comb begin
        case (funct3)
            `FUNCT3_ADD_SUB: begin
                // SUB only exists in register-register form
                if (opcode == `OP_OP && f7_alt) begin
                    base_func = `ALU_OP_SUB;
                end else begin
                    base_func = `ALU_OP_ADD;
                end
            end
            `FUNCT3_SLL:  base_func = `ALU_OP_SLL;
            `FUNCT3_SLT:  base_func = `ALU_OP_SLT;
            `FUNCT3_SLTU: base_func = `ALU_OP_SLTU;
            `FUNCT3_XOR:  base_func = `ALU_OP_XOR;
            `FUNCT3_SR:   base_func = f7_alt ? `ALU_OP_SRA : `ALU_OP_SRL;
            `FUNCT3_OR:   base_func = `ALU_OP_OR;
            default:      base_func = `ALU_OP_AND;
        endcase
    end

    always_comb begin
        alu_op1_o  = rd_port.rs1_value;
        alu_op2_o  = rd_port.rs2_value;
        alu_func_o = `ALU_OP_NOP;
        inst_legal = 1'b0;
        case (opcode)
            `OP_OP: begin
                alu_func_o = base_func;
                if (funct3 == `FUNCT3_ADD_SUB || funct3 == `FUNCT3_SR) begin
                    inst_legal = f7_base || f7_alt;
                end else begin
                    inst_legal = f7_base;
                end
            end
            `OP_OP_IMM: begin
                alu_func_o = base_func;
                alu_op2_o  = imm_i;
                case (funct3)
                    `FUNCT3_SLL: begin
                        alu_op2_o  = word_t'(shamt);
                        inst_legal = f7_base;
                    end
                    `FUNCT3_SR: begin
                        alu_op2_o  = word_t'(shamt);
                        inst_legal = f7_base || f7_alt;
                    end
                    default: inst_legal = 1'b1;
                endcase
            end
            `OP_LUI: begin
                alu_op1_o  = imm_u;
                alu_op2_o  = '0;
                alu_func_o = `ALU_OP_ADD;
                inst_legal = 1'b1;
            end
            `OP_AUIPC: begin
                alu_op1_o  = pc_i;
                alu_op2_o  = imm_u;
                alu_func_o = `ALU_OP_ADD;
                inst_legal = 1'b1;
            end
            `OP_JAL, `OP_JALR: begin
                // link value only, the target is computed elsewhere
                alu_op1_o  = pc_i;
                alu_op2_o  = word_t'(4);
                alu_func_o = `ALU_OP_ADD;
                inst_legal = (opcode == `OP_JAL) || (funct3 == 3'b000);
            end
            default: begin
                alu_op1_o = '0;
                alu_op2_o = '0;
            end
        endcase
    end

    // ******************************************************************
    // writeback register
    // ******************************************************************

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            writeback_valid_o <= 1'b0;
        end else begin
            writeback_valid_o <= issue_valid_i && inst_legal;
        end
    end

    always_ff @(posedge clk_i) begin
        writeback_rd_o    <= rd;
        writeback_value_o <= alu_out_i;
    end

endmodule

// File: int_exec.sv
// Integer execute slice top level: register file, arithmetic unit and ALU behind plain ports
`timescale 1ns/1ps

module int_exec import rv_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      issue_valid_i,
    input  word_t     pc_i,
    input  inst_t     inst_i,
    output logic      writeback_valid_o,
    output reg_addr_t writeback_rd_o,
    output word_t     writeback_value_o
);

    word_t   alu_op1;
    word_t   alu_op2;
    alu_op_t alu_func;
    word_t   alu_out;

    rf_read_if rf_rd ();

    // writeback also retires into the register file
    regfile regfile_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rd_port   (rf_rd.responder),
        .wr_en_i   (writeback_valid_o),
        .wr_addr_i (writeback_rd_o),
        .wr_data_i (writeback_value_o)
    );

    arith arith_i (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .issue_valid_i     (issue_valid_i),
        .pc_i              (pc_i),
        .inst_i            (inst_i),
        .rd_port           (rf_rd.requester),
        .alu_op1_o         (alu_op1),
        .alu_op2_o         (alu_op2),
        .alu_func_o        (alu_func),
        .alu_out_i         (alu_out),
        .writeback_valid_o (writeback_valid_o),
        .writeback_rd_o    (writeback_rd_o),
        .writeback_value_o (writeback_value_o)
    );

    alu alu_i (
        .alu_op1_i  (alu_op1),
        .alu_op2_i  (alu_op2),
        .alu_func_i (alu_func),
        .alu_out_o  (alu_out)
    );

endmodule

// File: int_exec_asserts.sv
// Writeback protocol assertions for the arithmetic unit, attached to arith by bind
`timescale 1ns/1ps
`include "rv_config.svh"

module int_exec_asserts import rv_pkg::*; (
    input logic  clk_i,
    input logic  rst_i,
    input logic  issue_valid_i,
    input inst_t inst_i,
    input logic  wb_valid_i
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       supported_op;
    logic       legal_enc;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign supported_op = (opcode == `OP_OP) || (opcode == `OP_OP_IMM)
                       || (opcode == `OP_LUI) || (opcode == `OP_AUIPC)
                       || (opcode == `OP_JAL) || (opcode == `OP_JALR);

    // legal RV32I base encodings in this slice
    always_comb begin
        case (opcode)
            `OP_OP: begin
                legal_enc = (funct7 == `FUNCT7_BASE) || ((funct7 == `FUNCT7_ALT)
                            && (funct3 == `FUNCT3_ADD_SUB || funct3 == `FUNCT3_SR));
            end
            `OP_OP_IMM: begin
                if (funct3 == `FUNCT3_SLL) begin
                    legal_enc = (funct7 == `FUNCT7_BASE);
                end else if (funct3 == `FUNCT3_SR) begin
                    legal_enc = (funct7 == `FUNCT7_BASE) || (funct7 == `FUNCT7_ALT);
                end else begin
                    legal_enc = 1'b1;
                end
            end
            `OP_LUI, `OP_AUIPC, `OP_JAL: legal_enc = 1'b1;
            `OP_JALR: legal_enc = (funct3 == 3'b000);
            default: legal_enc = 1'b0;
        endcase
    end

    a_reset_clears: assert property (@(posedge clk_i) rst_i |=> !wb_valid_i)
        else $error("writeback valid high after a reset cycle");

    a_legal_issue: assert property (@(posedge clk_i) disable iff (rst_i)
        (issue_valid_i && legal_enc) |=> wb_valid_i)
        else $error("legal issue without writeback one cycle later");

    a_no_spurious: assert property (@(posedge clk_i) disable iff (rst_i)
        !(issue_valid_i && legal_enc) |=> !wb_valid_i)
        else $error("writeback valid without a legal issue");

    a_unsupported: assert property (@(posedge clk_i) disable iff (rst_i)
        (issue_valid_i && !supported_op) |=> !wb_valid_i)
        else $error("writeback for an unsupported opcode");

endmodule

bind arith int_exec_asserts int_exec_asserts_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .inst_i        (inst_i),
    .wb_valid_i    (writeback_valid_o)
);

// File: regfile.sv
// 32-entry integer register file, two combinational read ports and one clocked write port
`timescale 1ns/1ps

module regfile import rv_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    rf_read_if.responder rd_port,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  word_t     wr_data_i
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // write-first read, so the next issue sees the value retiring this cycle
    function automatic word_t read_reg(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en_i && wr_addr_i == addr) begin
            value = wr_data_i;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rd_port.rs1_value = read_reg(rd_port.rs1_addr);
        rd_port.rs2_value = read_reg(rd_port.rs2_addr);
    end

endmodule

// File: rf_read_if.sv
// Two combinational register read ports between the arithmetic unit and the register file
`timescale 1ns/1ps

interface rf_read_if import rv_pkg::*; ();

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_value;
    word_t     rs2_value;

    // arithmetic unit side
    modport requester (
        output rs1_addr,
        output rs2_addr,
        input  rs1_value,
        input  rs2_value
    );

    // register file side
    modport responder (
        input  rs1_addr,
        input  rs2_addr,
        output rs1_value,
        output rs2_value
    );

endinterface

// File: run.sh
#!/bin/sh
# build the int_exec testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_int_exec -o tb_int_exec
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_int_exec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: rv_config.svh
// RV32I word width, opcode, funct and ALU operation encodings shared by RTL and testbench
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

`define XLEN 32

// major opcodes
`define OP_OP     7'b0110011
`define OP_OP_IMM 7'b0010011
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111

// funct3, shared by OP and OP-IMM
`define FUNCT3_ADD_SUB 3'b000
`define FUNCT3_SLL     3'b001
`define FUNCT3_SLT     3'b010
`define FUNCT3_SLTU    3'b011
`define FUNCT3_XOR     3'b100
`define FUNCT3_SR      3'b101
`define FUNCT3_OR      3'b110
`define FUNCT3_AND     3'b111

// funct7, alternate selects SUB and SRA/SRAI
`define FUNCT7_BASE 7'b0000000
`define FUNCT7_ALT  7'b0100000

`define ALU_OP_ADD  4'd0
`define ALU_OP_SUB  4'd1
`define ALU_OP_SLL  4'd2
`define ALU_OP_SLT  4'd3
`define ALU_OP_SLTU 4'd4
`define ALU_OP_XOR  4'd5
`define ALU_OP_SRL  4'd6
`define ALU_OP_SRA  4'd7
`define ALU_OP_OR   4'd8
`define ALU_OP_AND  4'd9
`define ALU_OP_NOP  4'd15

`endif

// File: rv_pkg.sv
// Vector types for data words, instructions, register indices and ALU codes, imported by all units
`include "rv_config.svh"

package rv_pkg;

    // data word, fixed by the ISA
    typedef logic [`XLEN-1:0] word_t;

    // raw 32-bit instruction
    typedef logic [31:0] inst_t;

    // one of x0..x31
    typedef logic [4:0] reg_addr_t;

    // operation select into the ALU
    typedef logic [3:0] alu_op_t;

endpackage

// File: tb_int_exec.sv
// Testbench for the integer execute slice: LFSR stimulus, reference model and writeback checks
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_int_exec import rv_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int N_LOAD = 31;
    localparam int N_RR = 64;
    localparam int N_IMM = 64;
    localparam int N_UPPER = 32;
    localparam int N_CHAIN = 16;
    localparam int N_X0 = 3;
    localparam int N_ILLEGAL = 16;
    localparam int N_READBACK = 31;
    localparam int TOTAL_ISSUES = N_LOAD + N_RR + N_IMM + N_UPPER + N_CHAIN + N_X0
                                  + N_ILLEGAL + N_READBACK;
    localparam int CYCLE_LIMIT = 2 * TOTAL_ISSUES + RESET_CYCLES;
    localparam logic [31:0] LFSR_SEED = 32'd94622;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic      clk;
    logic      rst;
    logic      issue_valid;
    word_t     pc;
    inst_t     inst;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_value;

    word_t       shadow [32];
    logic [31:0] lfsr_state;
    logic        exp_valid_q [$];
    reg_addr_t   exp_rd_q [$];
    word_t       exp_value_q [$];
    string       test_name;
    int          error_count;
    int          check_count;
    int          issue_count;
    int          test_errors;
    int          test_issues;
    int          cycle_count;

    int_exec int_exec_i (
        .clk_i             (clk),
        .rst_i             (rst),
        .issue_valid_i     (issue_valid),
        .pc_i              (pc),
        .inst_i            (inst),
        .writeback_valid_o (wb_valid),
        .writeback_rd_o    (wb_rd),
        .writeback_value_o (wb_value)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) return (state >> 1) ^ LFSR_TAPS;
        return state >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < n; b++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic inst_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
            input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd,
            input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic inst_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
            input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    // ******************************************************************
    // reference model, RV32I rules against the shadow registers
    // ******************************************************************

    function automatic logic ref_exec(input inst_t ins, input word_t pcv, output word_t result);
        logic [6:0] op;
        logic [2:0] f3;
        logic       base;
        logic       alt;
        logic       legal;
        word_t      a;
        word_t      b;
        op    = ins[6:0];
        f3    = ins[14:12];
        base  = (ins[31:25] == `FUNCT7_BASE);
        alt   = (ins[31:25] == `FUNCT7_ALT);
        a     = shadow[ins[19:15]];
        b     = shadow[ins[24:20]];
        legal = 1'b0;
        result = '0;
        if (op == `OP_OP || op == `OP_OP_IMM) begin
            if (op == `OP_OP_IMM) begin
                if (f3 == `FUNCT3_SLL || f3 == `FUNCT3_SR) b = {27'b0, ins[24:20]};
                else b = {{20{ins[31]}}, ins[31:20]};
            end
            if (f3 == `FUNCT3_SLL) legal = base;
            else if (f3 == `FUNCT3_SR) legal = base || alt;
            else if (op == `OP_OP_IMM) legal = 1'b1;
            else if (f3 == `FUNCT3_ADD_SUB) legal = base || alt;
            else legal = base;
            case (f3)
                `FUNCT3_ADD_SUB: result = (op == `OP_OP && alt) ? a - b : a + b;
                `FUNCT3_SLL:     result = a << b[4:0];
                `FUNCT3_SLT:     result = {31'b0, ($signed(a) < $signed(b))};
                `FUNCT3_SLTU:    result = {31'b0, (a < b)};
                `FUNCT3_XOR:     result = a ^ b;
                `FUNCT3_SR: begin
                    if (alt) result = word_t'($signed(a) >>> b[4:0]);
                    else result = a >> b[4:0];
                end
                `FUNCT3_OR:      result = a | b;
                default:         result = a & b;
            endcase
        end else if (op == `OP_LUI) begin
            legal  = 1'b1;
            result = {ins[31:12], 12'b0};
        end else if (op == `OP_AUIPC) begin
            legal  = 1'b1;
            result = pcv + {ins[31:12], 12'b0};
        end else if (op == `OP_JAL || op == `OP_JALR) begin
            legal  = (op == `OP_JAL) || (f3 == 3'b000);
            result = pcv + 32'd4;
        end
        return legal;
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("FAIL %s %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic issue(input inst_t ins, input word_t pcv);
        word_t result;
        logic  legal;
        @(negedge clk);
        legal = ref_exec(ins, pcv, result);
        exp_valid_q.push_back(legal);
        exp_rd_q.push_back(ins[11:7]);
        exp_value_q.push_back(result);
        issue_valid = 1'b1;
        pc          = pcv;
        inst        = ins;
        // x0 is never written
        if (legal && ins[11:7] != 5'd0) shadow[ins[11:7]] = result;
        issue_count++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = error_count;
        test_issues = issue_count;
    endtask

    task automatic end_test();
        @(negedge clk);
        issue_valid = 1'b0;
        while (exp_valid_q.size() != 0) @(negedge clk);
        $display("test %s done: %0d issues, %0d errors", test_name,
                 issue_count - test_issues, error_count - test_errors);
    endtask

    // compares one cycle after each issue, away from both clock edges
    initial begin : compare_proc
        logic      ev;
        reg_addr_t er;
        word_t     eval;
        forever begin
            @(posedge clk);
            #1;
            if (exp_valid_q.size() != 0) begin
                ev   = exp_valid_q.pop_front();
                er   = exp_rd_q.pop_front();
                eval = exp_value_q.pop_front();
                check("valid", {31'b0, ev}, {31'b0, wb_valid});
                if (ev) begin
                    check("rd", {27'b0, er}, {27'b0, wb_rd});
                    check("value", eval, wb_value);
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks failed");
        $finish;
    end

    initial begin : main_proc
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  op;
        logic [11:0] imm;
        reg_addr_t   rd;
        reg_addr_t   prev;
        word_t       pcv;
        rst         = 1'b1;
        issue_valid = 1'b0;
        pc          = '0;
        inst        = '0;
        lfsr_state  = LFSR_SEED;
        error_count = 0;
        check_count = 0;
        issue_count = 0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        start_test("reg_reg");
        for (int i = 1; i < 32; i++) begin
            rand_bits(12, r);
            issue(enc_i(r[11:0], 5'd0, `FUNCT3_ADD_SUB, reg_addr_t'(i), `OP_OP_IMM), '0);
        end
        for (int i = 0; i < N_RR; i++) begin
            f3 = i[2:0];
            f7 = (i[3] && (f3 == `FUNCT3_ADD_SUB || f3 == `FUNCT3_SR)) ? `FUNCT7_ALT
                                                                        : `FUNCT7_BASE;
            rand_bits(15, r);
            issue(enc_r(f7, r[14:10], r[9:5], f3, r[4:0], `OP_OP), '0);
        end
        end_test();

        start_test("reg_imm");
        for (int i = 0; i < N_IMM; i++) begin
            f3 = i[2:0];
            rand_bits(12, r);
            imm = r[11:0];
            if (f3 == `FUNCT3_SLL) imm[11:5] = `FUNCT7_BASE;
            else if (f3 == `FUNCT3_SR) imm[11:5] = i[3] ? `FUNCT7_ALT : `FUNCT7_BASE;
            rand_bits(10, r);
            issue(enc_i(imm, r[9:5], f3, r[4:0], `OP_OP_IMM), '0);
        end
        end_test();

        start_test("upper_link");
        for (int i = 0; i < N_UPPER; i++) begin
            rand_bits(30, r);
            pcv = {r[29:0], 2'b00};
            rand_bits(25, r);
            case (i[1:0])
                2'd0: issue({r[24:5], r[4:0], `OP_LUI}, pcv);
                2'd1: issue({r[24:5], r[4:0], `OP_AUIPC}, pcv);
                2'd2: issue({r[24:5], r[4:0], `OP_JAL}, pcv);
                default: issue(enc_i(r[24:13], r[12:8], 3'b000, r[4:0], `OP_JALR), pcv);
            endcase
        end
        end_test();

        start_test("dependency_chain");
        prev = 5'd1;
        for (int i = 0; i < N_CHAIN; i++) begin
            rand_bits(5, r);
            rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
            rand_bits(12, r);
            if (i[0]) issue(enc_i(r[11:0], prev, `FUNCT3_ADD_SUB, rd, `OP_OP_IMM), '0);
            else issue(enc_r(`FUNCT7_BASE, r[7:3], prev, r[2:0], rd, `OP_OP), '0);
            prev = rd;
        end
        end_test();

        start_test("x0_illegal");
        issue(enc_i(12'h123, 5'd1, `FUNCT3_ADD_SUB, 5'd0, `OP_OP_IMM), '0);
        issue(enc_r(`FUNCT7_BASE, 5'd0, 5'd0, `FUNCT3_ADD_SUB, 5'd7, `OP_OP), '0);
        issue(enc_i(12'h000, 5'd0, `FUNCT3_OR, 5'd8, `OP_OP_IMM), '0);
        for (int i = 0; i < N_ILLEGAL; i++) begin
            rand_bits(18, r);
            rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
            f3 = r[17:15];
            f7 = `FUNCT7_BASE;
            case (i[2:0])
                3'd0: op = 7'b0000011;
                3'd1: op = 7'b0100011;
                3'd2: op = 7'b1100011;
                3'd3: op = 7'b1110011;
                3'd4: begin
                    op = `OP_OP;
                    f3 = `FUNCT3_ADD_SUB;
                    f7 = 7'b0000001;
                end
                3'd5: begin
                    op = `OP_OP;
                    f3 = `FUNCT3_SR;
                    f7 = 7'b0100001;
                end
                3'd6: begin
                    op = `OP_OP_IMM;
                    f3 = `FUNCT3_SR;
                    f7 = 7'b0000010;
                end
                default: begin
                    op = `OP_JALR;
                    f3 = 3'b001;
                end
            endcase
            issue(enc_r(f7, r[14:10], r[9:5], f3, rd, op), '0);
        end
        // read every register back through x0
        for (int j = 1; j < 32; j++) begin
            issue(enc_r(`FUNCT7_BASE, 5'd0, reg_addr_t'(j), `FUNCT3_ADD_SUB, 5'd0, `OP_OP), '0);
        end
        end_test();

        $display("summary: %0d issues, %0d checks, %0d errors",
                 issue_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
rv_pkg.sv
rf_read_if.sv
alu.sv
regfile.sv
arith.sv
int_exec.sv
int_exec_asserts.sv
tb_int_exec.sv
